//--- source/mat_stream_pkg.sv
// Shared stream ids, priority order and memory opcode for the matrix engine memory port
package mat_stream_pkg;

  // Number of streamer ports in front of the shared memory port
  parameter int unsigned NumStreams = 4;

  // Width of a stream id, also the width of the mux winner register
  parameter int unsigned StreamIdW = $clog2(NumStreams);

  // Streamer port ids
  // The value is the mux channel index and the priority rank, lowest wins
  typedef enum logic [StreamIdW-1:0] {
    STREAM_W = 2'd0,  // W operand reader, highest priority
    STREAM_X = 2'd1,  // X operand reader
    STREAM_Y = 2'd2,  // Y operand reader
    STREAM_Z = 2'd3   // Z result writer, lowest priority
  } stream_id_e;

  // Memory port opcode
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } tcdm_op_e;

endpackage : mat_stream_pkg

//--- source/tcdm_if.sv
// Memory port bundle between a streamer, the port mux and the memory bank
`timescale 1ns/1ps

interface tcdm_if #(
  parameter int unsigned ADDR_W = 8,
  parameter int unsigned DATA_W = 32
);

  // Request side, held stable by the initiator until granted
  logic                     req;
  mat_stream_pkg::tcdm_op_e op;
  logic [ADDR_W-1:0]        add;   // Word address
  logic [DATA_W-1:0]        data;  // Write data

  // Response side
  logic                     gnt;
  logic                     r_valid;  // One cycle after a granted read
  logic [DATA_W-1:0]        r_data;

  modport initiator (
    output req, op, add, data,
    input  gnt, r_valid, r_data
  );

  modport target (
    input  req, op, add, data,
    output gnt, r_valid, r_data
  );

endinterface : tcdm_if

//--- source/stream_port_mux.sv
// Fixed-priority arbiter that merges the streamer ports onto the single memory port
`timescale 1ns/1ps

module stream_port_mux #(
  parameter int unsigned ADDR_W = 8,
  parameter int unsigned DATA_W = 32
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  tcdm_if.target    in [0:mat_stream_pkg::NumStreams-1],
  tcdm_if.initiator out
);

  localparam int unsigned NS = mat_stream_pkg::NumStreams;

  // Flattened request fields so the winner can index them
  logic [NS-1:0]             in_req;
  mat_stream_pkg::tcdm_op_e  in_op   [NS];
  logic [NS-1:0][ADDR_W-1:0] in_add;
  logic [NS-1:0][DATA_W-1:0] in_data;

  mat_stream_pkg::stream_id_e winner_d, winner_q;

  // Lowest id wins, so scan from the bottom of the order upwards
  always_comb begin
    winner_d = mat_stream_pkg::STREAM_W;
    for (int i = NS - 1; i >= 0; i--) begin
      if (in_req[i]) winner_d = mat_stream_pkg::stream_id_e'(i);
    end
  end

  // Remember who got the port for the read response next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      winner_q <= mat_stream_pkg::STREAM_W;
    end else if (clear_i) begin
      winner_q <= mat_stream_pkg::STREAM_W;
    end else if (out.req && out.gnt) begin
      winner_q <= winner_d;
    end
  end

  for (genvar ii = 0; ii < NS; ii++) begin : gen_chan
    assign in_req[ii]  = in[ii].req;
    assign in_op[ii]   = in[ii].op;
    assign in_add[ii]  = in[ii].add;
    assign in_data[ii] = in[ii].data;

    // Only the winner sees the grant
    assign in[ii].gnt     = (winner_d == ii) ? (in_req[ii] & out.gnt) : 1'b0;
    assign in[ii].r_valid = (winner_q == ii) ? out.r_valid : 1'b0;
    assign in[ii].r_data  = out.r_data;  // Broadcast
  end

  assign out.req  = in_req[winner_d];
  assign out.op   = in_op[winner_d];
  assign out.add  = in_add[winner_d];
  assign out.data = in_data[winner_d];

endmodule : stream_port_mux

//--- source/stream_reader.sv
// Read streamer that fetches len words from consecutive addresses and returns them as strobes
`timescale 1ns/1ps

module stream_reader #(
  parameter int unsigned ADDR_W = 8,
  parameter int unsigned DATA_W = 32,
  parameter int unsigned LEN_W  = 6
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  logic              start,
  input  logic [ADDR_W-1:0] base,
  input  logic [LEN_W-1:0]  len,
  output logic              rvalid,
  output logic [DATA_W-1:0] rdata,
  output logic              done,
  tcdm_if.initiator         mem
);

  typedef enum logic {
    IDLE,
    ISSUE
  } state_e;

  state_e             state_q;
  logic [ADDR_W-1:0]  addr_q;
  logic [LEN_W-1:0]   issue_left_q;  // Reads still to be granted
  logic [LEN_W-1:0]   resp_left_q;   // Responses still to come back
  logic               last_resp;

  assign last_resp = (state_q == ISSUE) && mem.r_valid && (resp_left_q == LEN_W'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      addr_q       <= '0;
      issue_left_q <= '0;
      resp_left_q  <= '0;
    end else if (clear_i) begin
      state_q      <= IDLE;
      issue_left_q <= '0;
      resp_left_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start && (len != '0)) begin  // Zero length is ignored
            state_q      <= ISSUE;
            addr_q       <= base;
            issue_left_q <= len;
            resp_left_q  <= len;
          end
        end
        ISSUE: begin
          if (mem.req && mem.gnt) begin
            addr_q       <= addr_q + 1'b1;
            issue_left_q <= issue_left_q - 1'b1;
          end
          if (mem.r_valid) resp_left_q <= resp_left_q - 1'b1;
          if (last_resp) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Address waits at the mux until granted
  assign mem.req  = (state_q == ISSUE) && (issue_left_q != '0);
  assign mem.op   = mat_stream_pkg::OP_READ;
  assign mem.add  = addr_q;
  assign mem.data = '0;

  assign rvalid = mem.r_valid;
  assign rdata  = mem.r_data;
  assign done   = last_resp;

endmodule : stream_reader

//--- source/stream_writer.sv
// Write streamer that buffers result words and stores them at consecutive addresses
`timescale 1ns/1ps

module stream_writer #(
  parameter int unsigned ADDR_W       = 8,
  parameter int unsigned DATA_W       = 32,
  parameter int unsigned Z_FIFO_DEPTH = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  logic              start,
  input  logic [ADDR_W-1:0] base,
  input  logic              valid,
  input  logic [DATA_W-1:0] wdata,
  output logic              done,
  output logic              overflow,
  tcdm_if.initiator         mem
);

  localparam int unsigned PTR_W = (Z_FIFO_DEPTH > 1) ? $clog2(Z_FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(Z_FIFO_DEPTH + 1);

  logic [DATA_W-1:0] fifo_q [Z_FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic [ADDR_W-1:0] addr_q;
  logic              full, push, pop;

  assign full = (count_q == CNT_W'(Z_FIFO_DEPTH));
  assign push = valid && !full;   // A word into a full FIFO is lost
  assign pop  = mem.req && mem.gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      overflow <= 1'b0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      overflow <= 1'b0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == PTR_W'(Z_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= (rd_ptr_q == PTR_W'(Z_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
      if (valid && full) overflow <= 1'b1;  // Sticky until clear
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push) fifo_q[wr_ptr_q] <= wdata;
  end

  // Start sets the base, each grant steps to the next word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (start) begin
      addr_q <= base;
    end else if (pop) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  assign mem.req  = (count_q != '0);
  assign mem.op   = mat_stream_pkg::OP_WRITE;
  assign mem.add  = addr_q;
  assign mem.data = fifo_q[rd_ptr_q];

  assign done = pop && (count_q == CNT_W'(1)) && !push;  // Last buffered word leaves

endmodule : stream_writer

//--- source/tcdm_bank.sv
// Single-bank memory model behind the port mux, always grants, one-cycle read latency
`timescale 1ns/1ps

module tcdm_bank #(
  parameter int unsigned ADDR_W = 8,
  parameter int unsigned DATA_W = 32
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  tcdm_if.target mem
);

  logic [DATA_W-1:0] mem_q [2**ADDR_W];
  logic              r_valid_q;
  logic [DATA_W-1:0] r_data_q;
  logic              rd_gnt, wr_gnt;

  assign mem.gnt = mem.req;  // No conflicts in a single bank

  assign rd_gnt = mem.req && mem.gnt && (mem.op == mat_stream_pkg::OP_READ);
  assign wr_gnt = mem.req && mem.gnt && (mem.op == mat_stream_pkg::OP_WRITE);

  always_ff @(posedge clk_i) begin
    if (wr_gnt) mem_q[mem.add] <= mem.data;
    if (rd_gnt) r_data_q <= mem_q[mem.add];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= rd_gnt;
    end
  end

  assign mem.r_valid = r_valid_q;
  assign mem.r_data  = r_data_q;

endmodule : tcdm_bank

//--- source/stream_subsystem_top.sv
// Top level of the streamer memory port: three readers and one writer sharing one bank
`timescale 1ns/1ps

module stream_subsystem_top #(
  parameter int unsigned ADDR_W       = 8,
  parameter int unsigned DATA_W       = 32,
  parameter int unsigned LEN_W        = 6,
  parameter int unsigned Z_FIFO_DEPTH = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  // W operand
  input  logic              w_start,
  input  logic [ADDR_W-1:0] w_base,
  input  logic [LEN_W-1:0]  w_len,
  output logic              w_rvalid,
  output logic [DATA_W-1:0] w_rdata,
  output logic              w_done,
  // X operand
  input  logic              x_start,
  input  logic [ADDR_W-1:0] x_base,
  input  logic [LEN_W-1:0]  x_len,
  output logic              x_rvalid,
  output logic [DATA_W-1:0] x_rdata,
  output logic              x_done,
  // Y operand
  input  logic              y_start,
  input  logic [ADDR_W-1:0] y_base,
  input  logic [LEN_W-1:0]  y_len,
  output logic              y_rvalid,
  output logic [DATA_W-1:0] y_rdata,
  output logic              y_done,
  // Z result
  input  logic              z_start,
  input  logic [ADDR_W-1:0] z_base,
  input  logic              z_valid,
  input  logic [DATA_W-1:0] z_data,
  output logic              z_done,
  output logic              z_overflow
);

  // One port per streamer, indexed by stream id
  tcdm_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) stream_if [0:mat_stream_pkg::NumStreams-1] ();
  tcdm_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) bank_if ();

  stream_reader #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .LEN_W(LEN_W)) w_reader_i (
    .clk_i, .rst_ni, .clear_i,
    .start (w_start), .base (w_base), .len (w_len),
    .rvalid(w_rvalid), .rdata(w_rdata), .done(w_done),
    .mem   (stream_if[mat_stream_pkg::STREAM_W])
  );

  stream_reader #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .LEN_W(LEN_W)) x_reader_i (
    .clk_i, .rst_ni, .clear_i,
    .start (x_start), .base (x_base), .len (x_len),
    .rvalid(x_rvalid), .rdata(x_rdata), .done(x_done),
    .mem   (stream_if[mat_stream_pkg::STREAM_X])
  );

  stream_reader #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .LEN_W(LEN_W)) y_reader_i (
    .clk_i, .rst_ni, .clear_i,
    .start (y_start), .base (y_base), .len (y_len),
    .rvalid(y_rvalid), .rdata(y_rdata), .done(y_done),
    .mem   (stream_if[mat_stream_pkg::STREAM_Y])
  );

  stream_writer #(
    .ADDR_W      (ADDR_W),
    .DATA_W      (DATA_W),
    .Z_FIFO_DEPTH(Z_FIFO_DEPTH)
  ) z_writer_i (
    .clk_i, .rst_ni, .clear_i,
    .start   (z_start),
    .base    (z_base),
    .valid   (z_valid),
    .wdata   (z_data),
    .done    (z_done),
    .overflow(z_overflow),
    .mem     (stream_if[mat_stream_pkg::STREAM_Z])
  );

  stream_port_mux #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) port_mux_i (
    .clk_i, .rst_ni, .clear_i,
    .in (stream_if),
    .out(bank_if)
  );

  tcdm_bank #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) bank_i (
    .clk_i, .rst_ni,
    .mem(bank_if)
  );

endmodule : stream_subsystem_top

//--- testbench/stream_subsystem_asserts.sv
// Protocol checks on the four streamer ports, bound into the subsystem top level
`timescale 1ns/1ps

module stream_subsystem_asserts (
  input logic                                  clk_i,
  input logic                                  rst_ni,
  input logic                                  clear_i,
  input logic [mat_stream_pkg::NumStreams-1:0] req,
  input logic [mat_stream_pkg::NumStreams-1:0] gnt,
  input logic [mat_stream_pkg::NumStreams-1:0] rvalid,
  input logic [mat_stream_pkg::NumStreams-1:0] is_read
);

  localparam int unsigned NS = mat_stream_pkg::NumStreams;

  logic [NS-1:0] rd_gnt;
  logic [NS-1:0] lower;  // Channels ranked above the granted one
  int unsigned   fail_prio;
  int unsigned   fail_onehot;
  int unsigned   fail_route;
  int unsigned   fail_hold;
  int unsigned   fail_clear;
  int unsigned   fail_cnt;

  assign rd_gnt   = req & gnt & is_read;
  assign lower    = gnt - NS'(1);
  assign fail_cnt = fail_prio + fail_onehot + fail_route + fail_hold + fail_clear;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (gnt != '0) |-> ((req & lower) == '0))
    else begin
      fail_prio++;
      $error("Grant went past a higher priority request");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(gnt))
    else begin
      fail_onehot++;
      $error("More than one channel granted in a cycle");
    end

  // Each read response lands on the channel granted one cycle before
  assert property (@(posedge clk_i) disable iff (!rst_ni) rvalid == $past(rd_gnt))
    else begin
      fail_route++;
      $error("Read response routed to the wrong channel");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (((req & ~gnt) != '0) && !clear_i) |=>
      ((req & $past(req & ~gnt)) == $past(req & ~gnt)))
    else begin
      fail_hold++;
      $error("Request dropped before it was granted");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) clear_i |=> (req == '0))
    else begin
      fail_clear++;
      $error("Request still high after clear");
    end

endmodule : stream_subsystem_asserts

bind stream_subsystem_top stream_subsystem_asserts asserts_i (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .clear_i(clear_i),
  .req    ({stream_if[3].req, stream_if[2].req, stream_if[1].req, stream_if[0].req}),
  .gnt    ({stream_if[3].gnt, stream_if[2].gnt, stream_if[1].gnt, stream_if[0].gnt}),
  .rvalid ({stream_if[3].r_valid, stream_if[2].r_valid,
            stream_if[1].r_valid, stream_if[0].r_valid}),
  .is_read({stream_if[3].op == mat_stream_pkg::OP_READ,
            stream_if[2].op == mat_stream_pkg::OP_READ,
            stream_if[1].op == mat_stream_pkg::OP_READ,
            stream_if[0].op == mat_stream_pkg::OP_READ})
);

//--- testbench/stream_subsystem_tb.sv
// Testbench for the streamer memory port, drives all four streams and checks read data
`timescale 1ns/1ps

module stream_subsystem_tb;

  localparam int unsigned ADDR_W       = 8;
  localparam int unsigned DATA_W       = 32;
  localparam int unsigned LEN_W        = 6;
  localparam int unsigned Z_FIFO_DEPTH = 4;
  localparam int unsigned MaxCycles    = 2000;  // Roughly 400 cycles of tests plus margin
  localparam logic [31:0] Seed         = 32'h898484e8;

  logic              clk_i;
  logic              rst_ni;
  logic              clear_i;
  logic [2:0]        rd_start;   // Index 0 is W, 1 is X, 2 is Y
  logic [2:0]        rd_rvalid;
  logic [2:0]        rd_done;
  logic [ADDR_W-1:0] rd_base  [3];
  logic [LEN_W-1:0]  rd_len   [3];
  logic [DATA_W-1:0] rd_rdata [3];
  logic              z_start;
  logic              z_valid;
  logic              z_done;
  logic              z_overflow;
  logic [ADDR_W-1:0] z_base;
  logic [DATA_W-1:0] z_data;

  logic [DATA_W-1:0] shadow [2**ADDR_W];  // Expected memory contents
  logic [ADDR_W-1:0] rd_addr [3];          // Next address each reader should return
  int unsigned rd_cnt [3];
  int unsigned exp_len [3];
  int unsigned done_cnt [3];
  int unsigned done_target [3];
  int unsigned first_cyc [3];
  int unsigned last_cyc [3];
  int unsigned z_done_cnt;
  int unsigned z_target;
  int unsigned cycle;
  int unsigned errors;
  int unsigned mon_errors;
  int unsigned err_start;
  int unsigned tests_passed;
  int unsigned tests_failed;
  int unsigned bound_fails;
  string       test_name;

  assign bound_fails = stream_subsystem_top_i.asserts_i.fail_cnt;

  stream_subsystem_top #(
    .ADDR_W      (ADDR_W),
    .DATA_W      (DATA_W),
    .LEN_W       (LEN_W),
    .Z_FIFO_DEPTH(Z_FIFO_DEPTH)
  ) stream_subsystem_top_i (
    .clk_i, .rst_ni, .clear_i,
    .w_start (rd_start[0]), .w_base (rd_base[0]), .w_len (rd_len[0]),
    .w_rvalid(rd_rvalid[0]), .w_rdata(rd_rdata[0]), .w_done(rd_done[0]),
    .x_start (rd_start[1]), .x_base (rd_base[1]), .x_len (rd_len[1]),
    .x_rvalid(rd_rvalid[1]), .x_rdata(rd_rdata[1]), .x_done(rd_done[1]),
    .y_start (rd_start[2]), .y_base (rd_base[2]), .y_len (rd_len[2]),
    .y_rvalid(rd_rvalid[2]), .y_rdata(rd_rdata[2]), .y_done(rd_done[2]),
    .z_start, .z_base, .z_valid, .z_data, .z_done, .z_overflow
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic void report_mismatch(input string what, input logic [DATA_W-1:0] exp,
                                          input logic [DATA_W-1:0] act);
    $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
  endfunction

  function automatic int unsigned total_errors();
    return errors + mon_errors + bound_fails;
  endfunction

  // Samples at the rising edge, before the DUT registers move
  always @(posedge clk_i) begin : monitor
    cycle = cycle + 1;
    if (cycle >= MaxCycles) begin
      $display("Run timed out after %0d cycles", cycle);
      $display("Some tests failed");
      $finish;
    end else if (rst_ni) begin
      for (int s = 0; s < 3; s++) begin
        if (rd_rvalid[s]) begin
          assert (rd_rdata[s] === shadow[rd_addr[s]]) else begin
            report_mismatch("read data", shadow[rd_addr[s]], rd_rdata[s]);
            mon_errors++;
          end
          rd_addr[s] = rd_addr[s] + ADDR_W'(1);
          rd_cnt[s]++;
          if (rd_cnt[s] == 1) first_cyc[s] = cycle;
          last_cyc[s] = cycle;
        end
        if (rd_done[s]) begin
          assert (rd_rvalid[s] && rd_cnt[s] == exp_len[s]) else begin
            $display("%s: done strobe did not come with the last word", test_name);
            mon_errors++;
          end
          done_cnt[s]++;
        end
        if (rd_start[s]) begin  // Reader takes the request at this edge
          rd_addr[s] = rd_base[s];
          rd_cnt[s]  = 0;
          exp_len[s] = 32'(rd_len[s]);
        end
      end
      if (z_done) z_done_cnt++;
    end
  end

  // Strobes last one cycle
  task automatic step();
    @(negedge clk_i);
    rd_start = '0;
    z_start  = 1'b0;
    z_valid  = 1'b0;
    clear_i  = 1'b0;
  endtask

  task automatic start_read(input int s, input logic [ADDR_W-1:0] base, input int len);
    rd_start[s]    = 1'b1;
    rd_base[s]     = base;
    rd_len[s]      = LEN_W'(len);
    done_target[s] = done_cnt[s] + 1;
  endtask

  task automatic wait_reads();
    for (int s = 0; s < 3; s++) begin
      while (done_cnt[s] < done_target[s]) @(negedge clk_i);
    end
  endtask

  task automatic write_words(input logic [ADDR_W-1:0] base, input int n, input int kept);
    logic [DATA_W-1:0] word;
    z_start  = 1'b1;
    z_base   = base;
    z_target = z_done_cnt + 1;
    step();
    for (int i = 0; i < n; i++) begin
      word    = DATA_W'($urandom);
      z_valid = 1'b1;
      z_data  = word;
      if (i < kept) shadow[base + ADDR_W'(i)] = word;  // Later words hit a full FIFO
      step();
    end
  endtask

  task automatic wait_z();
    while (z_done_cnt < z_target) @(negedge clk_i);
  endtask

  task automatic expect_true(input bit cond, input string msg);
    assert (cond) else begin
      $display("%s: %s", test_name, msg);
      errors++;
    end
  endtask

  task automatic expect_value(input string what, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
    assert (act === exp) else begin
      report_mismatch(what, exp, act);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_start = total_errors();
  endtask

  task automatic end_test();
    if (total_errors() == err_start) begin
      tests_passed++;
      $display("Test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("Test %s: FAILED", test_name);
    end
  endtask

  initial begin : stimulus
    logic [ADDR_W-1:0] b1;
    void'($urandom(Seed));
    rst_ni   = 1'b0;
    clear_i  = 1'b0;
    rd_start = '0;
    z_start  = 1'b0;
    z_valid  = 1'b0;
    z_base   = '0;
    z_data   = '0;
    for (int s = 0; s < 3; s++) begin
      rd_base[s] = '0;
      rd_len[s]  = '0;
    end
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    step();
    b1 = ADDR_W'($urandom);

    begin_test("write_readback");
    write_words(b1, 16, 16);
    wait_z();
    start_read(0, b1, 16);
    step();
    wait_reads();
    expect_true(z_done_cnt == z_target, "z_done pulsed more than once");
    end_test();

    begin_test("priority");
    start_read(0, b1, 8);
    start_read(1, b1 + ADDR_W'(4), 8);
    start_read(2, b1 + ADDR_W'(8), 8);
    step();
    wait_reads();
    expect_true(last_cyc[0] < first_cyc[1] && last_cyc[1] < first_cyc[2],
                "read streams were not served in priority order");
    end_test();

    begin_test("response_routing");
    start_read(1, b1, 6);
    step();
    step();
    start_read(2, b1 + ADDR_W'(10), 6);
    start_read(0, b1 + ADDR_W'(3), 3);  // Takes the port from X mid stream
    step();
    wait_reads();
    end_test();

    begin_test("writer_stall");
    start_read(0, b1, 10);
    write_words(b1 + ADDR_W'(16), 4, 4);
    wait_reads();
    wait_z();
    expect_value("z_overflow", '0, DATA_W'(z_overflow));
    start_read(0, b1 + ADDR_W'(16), 4);
    step();
    wait_reads();
    end_test();

    begin_test("overflow_clear");
    start_read(0, b1, 16);
    write_words(b1 + ADDR_W'(24), 6, Z_FIFO_DEPTH);  // W holds the port meanwhile
    wait_reads();
    expect_value("z_overflow before clear", DATA_W'(1), DATA_W'(z_overflow));
    clear_i = 1'b1;  // Z still has words queued and is requesting
    step();
    expect_value("z_overflow after clear", '0, DATA_W'(z_overflow));
    end_test();

    repeat (3) step();
    $display("Tests run %0d, passed %0d, failed %0d, assertion failures %0d",
             tests_passed + tests_failed, tests_passed, tests_failed, bound_fails);
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule : stream_subsystem_tb

//--- compile.f
source/mat_stream_pkg.sv
source/tcdm_if.sv
source/stream_port_mux.sv
source/stream_reader.sv
source/stream_writer.sv
source/tcdm_bank.sv
source/stream_subsystem_top.sv
testbench/stream_subsystem_asserts.sv
testbench/stream_subsystem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the streamer subsystem testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

top="stream_subsystem_tb"
log_file="sim.log"

verilator --binary --timing --assert --top-module "$top" -f compile.f -o sim_bin
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_bin +verilator+error+limit+1000 > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "All tests passed" "$log_file"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
